//--- design/cp0_pkg.sv
package cp0_pkg;

    // Exceptions that the prioritizer can report, one per instruction
    typedef enum logic [3:0] {
        NONE       = 4'd0,
        INTR       = 4'd1,
        ADEL_FETCH = 4'd2,
        ADEL_LOAD  = 4'd3,
        ADES       = 4'd4,
        OV         = 4'd5,
        SYSC       = 4'd6,
        BP         = 4'd7,
        RI         = 4'd8,
        ERET       = 4'd9
    } exc_kind_t;

    // Bit index of each kind in the pipeline request vector
    localparam int REQ_ADEL_FETCH = 0;
    localparam int REQ_ADEL_LOAD  = 1;
    localparam int REQ_ADES       = 2;
    localparam int REQ_OV         = 3;
    localparam int REQ_SYSC       = 4;
    localparam int REQ_BP         = 5;
    localparam int REQ_RI         = 6;

    // Cause ExcCode values
    localparam logic [4:0] EXC_INTR = 5'd0;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;

    // Register number times 8 plus select
    localparam logic [7:0] REG_BADVADDR = 8'd64;
    localparam logic [7:0] REG_COUNT    = 8'd72;
    localparam logic [7:0] REG_COMPARE  = 8'd88;
    localparam logic [7:0] REG_STATUS   = 8'd96;
    localparam logic [7:0] REG_CAUSE    = 8'd104;
    localparam logic [7:0] REG_EPC      = 8'd112;
    localparam logic [7:0] REG_PRID     = 8'd120;
    localparam logic [7:0] REG_CONFIG   = 8'd128;
    localparam logic [7:0] REG_CONFIG1  = 8'd129;
    localparam logic [7:0] REG_ERROREPC = 8'd240;

    // Status fields
    localparam int ST_BEV   = 22;
    localparam int ST_IM_HI = 15;
    localparam int ST_IM_LO = 8;
    localparam int ST_EXL   = 1;
    localparam int ST_IE    = 0;

    // Cause fields
    localparam int CA_BD     = 31;
    localparam int CA_TI     = 30;
    localparam int CA_IP_HI  = 15;
    localparam int CA_IP_LO  = 8;
    localparam int CA_EXC_HI = 6;
    localparam int CA_EXC_LO = 2;

    // Read-only identification, Config1 reports 64B 4-way caches and 32 TLB slots
    localparam logic [31:0] PRID_VALUE    = 32'h0001_8021;
    localparam logic [31:0] CONFIG1_VALUE = 32'h3E2B_1580;

    // Exception entry points
    localparam logic [31:0] VEC_BOOT   = 32'hBFC0_0380;
    localparam logic [31:0] VEC_NORMAL = 32'h8000_0180;

endpackage

//--- design/cp0_timer.sv
`timescale 1ns/1ps

module cp0_timer #(
    parameter int unsigned TIMER_DIV = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        count_wen_i,
    input  logic        compare_wen_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] count_o,
    output logic [31:0] compare_o,
    output logic        timer_irq_o
);

    // Prescaler wide enough to hold TIMER_DIV-1
    localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

    logic [DIV_W-1:0] presc;
    logic             tick;
    logic             match;

    // One Count step per TIMER_DIV clocks
    assign tick  = (presc == DIV_W'(TIMER_DIV - 1));
    // Zero Compare means timer disabled
    assign match = (count_o == compare_o) && (compare_o != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc       <= '0;
            count_o     <= '0;
            compare_o   <= '0;
            timer_irq_o <= 1'b0;
        end else begin
            // Software load restarts the prescaler
            if (count_wen_i) begin
                count_o <= wdata_i;
                presc   <= '0;
            end else if (tick) begin
                count_o <= count_o + 32'd1;
                presc   <= '0;
            end else begin
                presc <= presc + 1'b1;
            end
            if (compare_wen_i) begin
                compare_o <= wdata_i;
            end
            // Sticky until Compare is rewritten
            if (compare_wen_i) begin
                timer_irq_o <= 1'b0;
            end else if (match) begin
                timer_irq_o <= 1'b1;
            end
        end
    end

endmodule

//--- design/exc_prioritizer.sv
`timescale 1ns/1ps

module exc_prioritizer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_valid_i,
    input  logic [31:0]          inst_pc_i,
    input  logic                 inst_inslot_i,
    input  logic [6:0]           exc_req_i,
    input  logic                 eret_i,
    input  logic [31:0]          exc_baddr_i,
    input  logic                 int_pending_i,
    input  logic                 status_bev_i,
    input  logic [31:0]          epc_i,
    output logic                 exc_valid_o,
    output cp0_pkg::exc_kind_t   exc_kind_o,
    output logic [31:0]          exc_pc_o,
    output logic                 exc_inslot_o,
    output logic [31:0]          exc_baddr_o,
    output logic                 redirect_o,
    output logic [31:0]          redirect_pc_o
);

    import cp0_pkg::*;

    exc_kind_t   kind_d;
    logic        valid_d;
    logic [31:0] target_d;

    // Fixed priority, interrupt first, ERET last
    always_comb begin
        kind_d = NONE;
        if (inst_valid_i) begin
            if (int_pending_i) begin
                kind_d = INTR;
            end else if (exc_req_i[REQ_ADEL_FETCH]) begin
                kind_d = ADEL_FETCH;
            end else if (exc_req_i[REQ_RI]) begin
                kind_d = RI;
            end else if (exc_req_i[REQ_OV]) begin
                kind_d = OV;
            end else if (exc_req_i[REQ_SYSC]) begin
                kind_d = SYSC;
            end else if (exc_req_i[REQ_BP]) begin
                kind_d = BP;
            end else if (exc_req_i[REQ_ADEL_LOAD]) begin
                kind_d = ADEL_LOAD;
            end else if (exc_req_i[REQ_ADES]) begin
                kind_d = ADES;
            end else if (eret_i) begin
                kind_d = ERET;
            end
        end
    end

    assign valid_d = (kind_d != NONE);

    // ERET returns to EPC, all others enter the handler
    always_comb begin
        if (kind_d == ERET) begin
            target_d = epc_i;
        end else begin
            target_d = status_bev_i ? VEC_BOOT : VEC_NORMAL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exc_valid_o <= 1'b0;
            exc_kind_o  <= NONE;
            redirect_o  <= 1'b0;
        end else begin
            exc_valid_o <= valid_d;
            exc_kind_o  <= kind_d;
            redirect_o  <= valid_d;
        end
    end

    // Payload of the decision, qualified by exc_valid_o
    always_ff @(posedge clk) begin
        exc_pc_o      <= inst_pc_i;
        exc_inslot_o  <= inst_inslot_i;
        exc_baddr_o   <= exc_baddr_i;
        redirect_pc_o <= target_d;
    end

endmodule

//--- design/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs #(
    parameter logic [31:0] ERROREPC_RESET = 32'hBFC0_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [5:0]         hw_intr_i,
    input  logic [7:0]         reg_addr_i,
    input  logic               reg_wen_i,
    input  logic [31:0]        reg_wdata_i,
    input  logic               exc_valid_i,
    input  cp0_pkg::exc_kind_t exc_kind_i,
    input  logic [31:0]        exc_pc_i,
    input  logic               exc_inslot_i,
    input  logic [31:0]        exc_baddr_i,
    input  logic [31:0]        count_i,
    input  logic [31:0]        compare_i,
    input  logic               timer_irq_i,
    output logic [31:0]        reg_rdata_o,
    output logic               count_wen_o,
    output logic               compare_wen_o,
    output logic               int_pending_o,
    output logic [31:0]        status_o,
    output logic [31:0]        cause_o,
    output logic [31:0]        epc_o
);

    import cp0_pkg::*;

    // Status fields
    logic        status_bev;
    logic [7:0]  status_im;
    logic        status_exl;
    logic        status_ie;

    // Cause fields
    logic        cause_bd;
    logic        cause_ti;
    logic [7:0]  cause_ip;
    logic [4:0]  cause_exc;

    logic [31:0] badvaddr;
    logic [31:0] epc;
    logic [31:0] errorepc;
    logic [2:0]  config_k0;
    logic [31:0] config_w;

    logic        exc_enter;
    logic        addr_err;
    logic        wr_en;
    logic [4:0]  exc_code;

    // Exception always beats a bus write in the same cycle
    assign wr_en     = reg_wen_i && !exc_valid_i;
    assign exc_enter = exc_valid_i && (exc_kind_i != ERET);
    assign addr_err  = (exc_kind_i == ADEL_FETCH) || (exc_kind_i == ADEL_LOAD) ||
                       (exc_kind_i == ADES);

    // Timer registers live in cp0_timer
    assign count_wen_o   = wr_en && (reg_addr_i == REG_COUNT);
    assign compare_wen_o = wr_en && (reg_addr_i == REG_COMPARE);

    always_comb begin
        case (exc_kind_i)
            ADEL_FETCH, ADEL_LOAD: exc_code = EXC_ADEL;
            ADES:                  exc_code = EXC_ADES;
            OV:                    exc_code = EXC_OV;
            SYSC:                  exc_code = EXC_SYS;
            BP:                    exc_code = EXC_BP;
            RI:                    exc_code = EXC_RI;
            default:               exc_code = EXC_INTR;
        endcase
    end

    // Pack the architectural views
    always_comb begin
        status_o                    = '0;
        status_o[ST_BEV]            = status_bev;
        status_o[ST_IM_HI:ST_IM_LO] = status_im;
        status_o[ST_EXL]            = status_exl;
        status_o[ST_IE]             = status_ie;
        cause_o                       = '0;
        cause_o[CA_BD]                = cause_bd;
        cause_o[CA_TI]                = cause_ti;
        cause_o[CA_IP_HI:CA_IP_LO]    = cause_ip;
        cause_o[CA_EXC_HI:CA_EXC_LO]  = cause_exc;
    end

    // M bit set, Config1 present; K0 writable
    assign config_w = {1'b1, 23'b0, 1'b1, 3'b0, 1'b0, config_k0};
    assign epc_o    = epc;

    // Masked pending lines, blocked inside a handler
    assign int_pending_o = |(cause_ip & status_im) && status_ie && !status_exl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_bev <= 1'b1;
            status_im  <= '0;
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
            cause_bd   <= 1'b0;
            cause_ti   <= 1'b0;
            cause_ip   <= '0;
            cause_exc  <= '0;
            badvaddr   <= '0;
            epc        <= '0;
            errorepc   <= ERROREPC_RESET;
            config_k0  <= 3'd3;
        end else begin
            // Hardware lines, timer shares IP7 with line 5
            cause_ip[7:2] <= {hw_intr_i[5] | timer_irq_i, hw_intr_i[4:0]};
            cause_ti      <= timer_irq_i;
            if (exc_valid_i) begin
                if (exc_enter) begin
                    // Nested exception keeps the first return point
                    if (!status_exl) begin
                        epc      <= exc_inslot_i ? exc_pc_i - 32'd4 : exc_pc_i;
                        cause_bd <= exc_inslot_i;
                        if (addr_err) begin
                            badvaddr <= exc_baddr_i;
                        end
                    end
                    status_exl <= 1'b1;
                    cause_exc  <= exc_code;
                end else begin
                    status_exl <= 1'b0;
                end
            end else if (wr_en) begin
                case (reg_addr_i)
                    REG_BADVADDR: badvaddr <= reg_wdata_i;
                    REG_STATUS: begin
                        status_bev <= reg_wdata_i[ST_BEV];
                        status_im  <= reg_wdata_i[ST_IM_HI:ST_IM_LO];
                        status_exl <= reg_wdata_i[ST_EXL];
                        status_ie  <= reg_wdata_i[ST_IE];
                    end
                    // Only the two software interrupt bits
                    REG_CAUSE:    cause_ip[1:0] <= reg_wdata_i[CA_IP_LO+1:CA_IP_LO];
                    REG_EPC:      epc <= reg_wdata_i;
                    REG_CONFIG:   config_k0 <= reg_wdata_i[2:0];
                    REG_ERROREPC: errorepc <= reg_wdata_i;
                    default: ;
                endcase
            end
        end
    end

    // Read decode, unknown addresses give zero
    always_comb begin
        case (reg_addr_i)
            REG_BADVADDR: reg_rdata_o = badvaddr;
            REG_COUNT:    reg_rdata_o = count_i;
            REG_COMPARE:  reg_rdata_o = compare_i;
            REG_STATUS:   reg_rdata_o = status_o;
            REG_CAUSE:    reg_rdata_o = cause_o;
            REG_EPC:      reg_rdata_o = epc;
            REG_PRID:     reg_rdata_o = PRID_VALUE;
            REG_CONFIG:   reg_rdata_o = config_w;
            REG_CONFIG1:  reg_rdata_o = CONFIG1_VALUE;
            REG_ERROREPC: reg_rdata_o = errorepc;
            default:      reg_rdata_o = '0;
        endcase
    end

endmodule

//--- design/cp0_wb_slave.sv
`timescale 1ns/1ps

module cp0_wb_slave (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [7:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    input  logic [31:0] reg_rdata_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,
    output logic [7:0]  reg_addr_o,
    output logic        reg_wen_o,
    output logic [31:0] reg_wdata_o
);

    typedef enum logic {S_IDLE, S_BUSY} state_t;

    state_t state;
    logic   req;

    // Valid request; ack_o high means the master is still closing the last one
    assign req = wb_cyc_i && wb_stb_i;

    // Master holds address and data until ack
    assign reg_addr_o  = wb_adr_i;
    assign reg_wdata_o = wb_dat_i;
    // Partial writes are acked but never reach the registers
    assign reg_wen_o   = (state == S_BUSY) && req && wb_we_i && (wb_sel_i == 4'hF);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;
            case (state)
                S_IDLE: if (req && !wb_ack_o) state <= S_BUSY;
                S_BUSY: begin
                    state    <= S_IDLE;
                    wb_ack_o <= req;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Read data captured on the ack edge
    always_ff @(posedge clk) begin
        if (state == S_BUSY) wb_dat_o <= reg_rdata_i;
    end

endmodule

//--- design/cp0_top.sv
`timescale 1ns/1ps

module cp0_top #(
    parameter int unsigned TIMER_DIV      = 2,
    parameter logic [31:0] ERROREPC_RESET = 32'hBFC0_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    // Wishbone slave
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [7:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,
    // Hardware interrupt lines 2..7
    input  logic [5:0]  hw_intr_i,
    // Retiring instruction from the pipeline
    input  logic        inst_valid_i,
    input  logic [31:0] inst_pc_i,
    input  logic        inst_inslot_i,
    input  logic [6:0]  exc_req_i,
    input  logic        eret_i,
    input  logic [31:0] exc_baddr_i,
    output logic        redirect_o,
    output logic [31:0] redirect_pc_o,
    output logic [31:0] status_o,
    output logic [31:0] cause_o,
    output logic [31:0] epc_o
);

    import cp0_pkg::*;

    // Register access path
    logic [7:0]  reg_addr;
    logic        reg_wen;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;

    // Timer
    logic        count_wen;
    logic        compare_wen;
    logic [31:0] count;
    logic [31:0] compare;
    logic        timer_irq;

    // Registered exception decision
    logic        exc_valid;
    exc_kind_t   exc_kind;
    logic [31:0] exc_pc;
    logic        exc_inslot;
    logic [31:0] exc_baddr;
    logic        int_pending;

    cp0_wb_slave wb_i (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
        .reg_rdata_i(reg_rdata), .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
        .reg_addr_o(reg_addr), .reg_wen_o(reg_wen), .reg_wdata_o(reg_wdata)
    );

    cp0_timer #(.TIMER_DIV(TIMER_DIV)) timer_i (
        .clk(clk), .rst_n(rst_n),
        .count_wen_i(count_wen), .compare_wen_i(compare_wen), .wdata_i(reg_wdata),
        .count_o(count), .compare_o(compare), .timer_irq_o(timer_irq)
    );

    exc_prioritizer prio_i (
        .clk(clk), .rst_n(rst_n),
        .inst_valid_i(inst_valid_i), .inst_pc_i(inst_pc_i), .inst_inslot_i(inst_inslot_i),
        .exc_req_i(exc_req_i), .eret_i(eret_i), .exc_baddr_i(exc_baddr_i),
        .int_pending_i(int_pending), .status_bev_i(status_o[ST_BEV]), .epc_i(epc_o),
        .exc_valid_o(exc_valid), .exc_kind_o(exc_kind), .exc_pc_o(exc_pc),
        .exc_inslot_o(exc_inslot), .exc_baddr_o(exc_baddr),
        .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o)
    );

    cp0_regs #(.ERROREPC_RESET(ERROREPC_RESET)) regs_i (
        .clk(clk), .rst_n(rst_n), .hw_intr_i(hw_intr_i),
        .reg_addr_i(reg_addr), .reg_wen_i(reg_wen), .reg_wdata_i(reg_wdata),
        .exc_valid_i(exc_valid), .exc_kind_i(exc_kind), .exc_pc_i(exc_pc),
        .exc_inslot_i(exc_inslot), .exc_baddr_i(exc_baddr),
        .count_i(count), .compare_i(compare), .timer_irq_i(timer_irq),
        .reg_rdata_o(reg_rdata), .count_wen_o(count_wen), .compare_wen_o(compare_wen),
        .int_pending_o(int_pending), .status_o(status_o), .cause_o(cause_o), .epc_o(epc_o)
    );

endmodule

//--- verif/cp0_asserts.sv
`timescale 1ns/1ps

module cp0_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               wb_cyc_i,
    input logic               wb_stb_i,
    input logic               wb_ack_o,
    input logic               inst_valid_i,
    input logic               redirect_o,
    input cp0_pkg::exc_kind_t exc_kind_i,
    input logic               status_exl_i
);

    import cp0_pkg::*;

    // One-cycle ack
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_o |=> !wb_ack_o) else $error("ack held for two cycles");

    // Ack answers a strobe seen the cycle before
    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)) else $error("ack without strobe");

    // Redirect only for a retired instruction
    redirect_one: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o |-> $past(inst_valid_i)) else $error("redirect without instruction");

    // Handler entry sets EXL
    exl_on_entry: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect_o && exc_kind_i != ERET) |=> status_exl_i) else $error("EXL not set");

endmodule

bind cp0_top cp0_asserts asserts_i (
    .clk(clk), .rst_n(rst_n), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_ack_o(wb_ack_o), .inst_valid_i(inst_valid_i), .redirect_o(redirect_o),
    .exc_kind_i(exc_kind), .status_exl_i(status_o[1])
);

//--- verif/cp0_tb.sv
`timescale 1ns/1ps

module cp0_tb;

    import cp0_pkg::*;

    localparam int unsigned TIMER_DIV = 2;
    localparam int N_REG = 40;
    localparam int N_TMR = 12;
    localparam int N_EXC = 60;
    localparam int N_INT = 40;
    // Rough per-iteration cycle costs of each test plus margin
    localparam int MAX_CYC = 40 + N_REG * 16 + 40 + N_TMR * 14 + N_EXC * 16 + 8 * 24
                             + N_INT * 20 + 400;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [7:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;
    logic [5:0]  hw_intr_i;
    logic        inst_valid_i;
    logic [31:0] inst_pc_i;
    logic        inst_inslot_i;
    logic [6:0]  exc_req_i;
    logic        eret_i;
    logic [31:0] exc_baddr_i;
    logic        redirect_o;
    logic [31:0] redirect_pc_o;
    logic [31:0] status_o;
    logic [31:0] cause_o;
    logic [31:0] epc_o;

    // Reference model of the register state
    logic        m_bev;
    logic        m_exl;
    logic        m_ie;
    logic        m_bd;
    logic [7:0]  m_im;
    logic [1:0]  m_sw;
    logic [5:0]  m_hw;
    logic [4:0]  m_exc;
    logic [31:0] m_badv;
    logic [31:0] m_epc;
    logic [31:0] m_errepc;
    logic [31:0] m_cmp;
    logic [2:0]  m_k0;
    // Count model anchor, value and edge of the last Count write
    logic [31:0] c_base;
    int          c_edge;

    int err_cnt;
    int chk_cnt;
    int edge_cnt;

    cp0_top #(.TIMER_DIV(TIMER_DIV)) dut_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Edge counter and watchdog
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
        if (edge_cnt >= MAX_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("** Error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] status_exp();
        return {9'b0, m_bev, 6'b0, m_im, 6'b0, m_exl, m_ie};
    endfunction

    // IP7 is the timer ORed with line 5
    function automatic logic [31:0] cause_exp(input logic ti);
        return {m_bd, ti, 14'b0, ti | m_hw[5], m_hw[4:0], m_sw, 1'b0, m_exc, 2'b0};
    endfunction

    function automatic logic [31:0] model_count(input int e);
        return c_base + 32'((e - c_edge) / int'(TIMER_DIV));
    endfunction

    function automatic logic is_known(input logic [7:0] a);
        return a inside {REG_BADVADDR, REG_COUNT, REG_COMPARE, REG_STATUS, REG_CAUSE,
                         REG_EPC, REG_PRID, REG_CONFIG, REG_CONFIG1, REG_ERROREPC};
    endfunction

    function automatic logic [31:0] read_exp(input logic [7:0] a);
        case (a)
            REG_BADVADDR: return m_badv;
            REG_COMPARE:  return m_cmp;
            REG_STATUS:   return status_exp();
            REG_CAUSE:    return cause_exp(1'b0);
            REG_EPC:      return m_epc;
            REG_PRID:     return PRID_VALUE;
            REG_CONFIG:   return 32'h8000_0080 | {29'b0, m_k0};
            REG_CONFIG1:  return CONFIG1_VALUE;
            REG_ERROREPC: return m_errepc;
            default:      return 32'h0;
        endcase
    endfunction

    task automatic write_model(input logic [7:0] a, input logic [31:0] d);
        case (a)
            REG_BADVADDR: m_badv = d;
            REG_COMPARE:  m_cmp = d;
            REG_STATUS: begin
                m_bev = d[22];
                m_im  = d[15:8];
                m_exl = d[1];
                m_ie  = d[0];
            end
            REG_CAUSE:    m_sw = d[9:8];
            REG_EPC:      m_epc = d;
            REG_CONFIG:   m_k0 = d[2:0];
            REG_ERROREPC: m_errepc = d;
            default: ;
        endcase
    endtask

    // One Wishbone classic cycle, held until ack
    task automatic bus_xfer(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdata,
                            output int ack_edge);
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        @(negedge clk);
        while (!wb_ack_o) @(negedge clk);
        ack_edge = edge_cnt;
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] rd;
        int          e;
        bus_xfer(1'b1, adr, dat, 4'hF, rd, e);
        write_model(adr, dat);
    endtask

    task automatic bus_read(input logic [7:0] adr, output logic [31:0] rd);
        int e;
        bus_xfer(1'b0, adr, 32'h0, 4'hF, rd, e);
    endtask

    function automatic exc_kind_t pick_kind(input logic [6:0] req, input logic eret,
                                            input logic intp);
        if (intp) return INTR;
        if (req[REQ_ADEL_FETCH]) return ADEL_FETCH;
        if (req[REQ_RI]) return RI;
        if (req[REQ_OV]) return OV;
        if (req[REQ_SYSC]) return SYSC;
        if (req[REQ_BP]) return BP;
        if (req[REQ_ADEL_LOAD]) return ADEL_LOAD;
        if (req[REQ_ADES]) return ADES;
        if (eret) return ERET;
        return NONE;
    endfunction

    function automatic logic [4:0] code_of(input exc_kind_t k);
        case (k)
            ADEL_FETCH, ADEL_LOAD: return 5'd4;
            ADES:                  return 5'd5;
            OV:                    return 5'd12;
            SYSC:                  return 5'd8;
            BP:                    return 5'd9;
            RI:                    return 5'd10;
            default:               return 5'd0;
        endcase
    endfunction

    task automatic apply_exc(input exc_kind_t k, input logic [31:0] pc, input logic inslot,
                             input logic [31:0] baddr);
        if (k == ERET) begin
            m_exl = 1'b0;
        end else if (k != NONE) begin
            // First exception owns EPC until ERET
            if (!m_exl) begin
                m_epc = inslot ? pc - 32'd4 : pc;
                m_bd  = inslot;
                if (k inside {ADEL_FETCH, ADEL_LOAD, ADES}) m_badv = baddr;
            end
            m_exl = 1'b1;
            m_exc = code_of(k);
        end
    endtask

    // Retire one instruction, check redirect and the recorded state
    task automatic issue_inst(input logic [31:0] pc, input logic inslot, input logic [6:0] req,
                              input logic eret, input logic [31:0] baddr, input string name);
        exc_kind_t   kind;
        logic        intp;
        logic [31:0] target;
        intp   = (|({m_hw, m_sw} & m_im)) && m_ie && !m_exl;
        kind   = pick_kind(req, eret, intp);
        target = (kind == ERET) ? m_epc : (m_bev ? VEC_BOOT : VEC_NORMAL);
        @(negedge clk);
        inst_valid_i  = 1'b1;
        inst_pc_i     = pc;
        inst_inslot_i = inslot;
        exc_req_i     = req;
        eret_i        = eret;
        exc_baddr_i   = baddr;
        @(negedge clk);
        inst_valid_i = 1'b0;
        exc_req_i    = '0;
        eret_i       = 1'b0;
        check({name, " redirect"}, {31'b0, kind != NONE}, {31'b0, redirect_o});
        if (kind != NONE) check({name, " target"}, target, redirect_pc_o);
        apply_exc(kind, pc, inslot, baddr);
        @(negedge clk);
        check({name, " status"}, status_exp(), status_o);
        check({name, " bd"}, {31'b0, m_bd}, {31'b0, cause_o[31]});
        check({name, " exccode"}, {27'b0, m_exc}, {27'b0, cause_o[6:2]});
        check({name, " epc"}, m_epc, epc_o);
    endtask

    initial begin
        logic [7:0]  wr_addrs [7];
        logic [7:0]  a;
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] rd;
        int          e;

        void'($urandom(40));
        wr_addrs = '{REG_BADVADDR, REG_STATUS, REG_CAUSE, REG_EPC, REG_CONFIG,
                     REG_ERROREPC, REG_COMPARE};
        err_cnt = 0;
        chk_cnt = 0;
        edge_cnt = 0;
        rst_n = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        hw_intr_i = '0;
        inst_valid_i = 1'b0;
        inst_pc_i = '0;
        inst_inslot_i = 1'b0;
        exc_req_i = '0;
        eret_i = 1'b0;
        exc_baddr_i = '0;
        // Reset view of the registers
        m_bev = 1'b1;
        m_exl = 1'b0;
        m_ie = 1'b0;
        m_bd = 1'b0;
        m_im = '0;
        m_sw = '0;
        m_hw = '0;
        m_exc = '0;
        m_badv = '0;
        m_epc = '0;
        m_errepc = 32'hBFC0_0000;
        m_cmp = '0;
        m_k0 = 3'd3;
        c_base = '0;
        c_edge = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Register write and readback, with the odd partial write
        for (int i = 0; i < N_REG; i++) begin
            r = $urandom;
            a = wr_addrs[r % 7];
            d = $urandom;
            if (a == REG_COMPARE) d = d | 32'h8000_0000;
            if (r[8] && r[9]) begin
                bus_xfer(1'b1, a, d, 4'h3, rd, e);
            end else begin
                bus_write(a, d);
            end
            bus_read(a, rd);
            check("regs", read_exp(a), rd);
        end
        bus_read(REG_PRID, rd);
        check("prid", PRID_VALUE, rd);
        bus_read(REG_CONFIG1, rd);
        check("config1", CONFIG1_VALUE, rd);
        for (int i = 0; i < 5; i++) begin
            r = $urandom;
            a = r[7:0];
            while (is_known(a)) begin
                a = a + 8'd1;
            end
            bus_read(a, rd);
            check("unknown addr", 32'h0, rd);
        end

        // Timer, Compare a few steps ahead of Count
        r = $urandom;
        c_base = (r & 32'h00FF_FFFF) | 32'h0001_0000;
        bus_write(REG_COMPARE, c_base + 32'd6);
        bus_xfer(1'b1, REG_COUNT, c_base, 4'hF, rd, c_edge);
        repeat (2) @(negedge clk);
        for (int i = 0; i < N_TMR; i++) begin
            r = $urandom;
            repeat (r % 3) @(negedge clk);
            bus_xfer(1'b0, REG_COUNT, 32'h0, 4'hF, rd, e);
            check("timer count", model_count(e - 1), rd);
            bus_xfer(1'b0, REG_CAUSE, 32'h0, 4'hF, rd, e);
            check("timer cause", cause_exp(model_count(e - 3) >= m_cmp), rd);
        end
        bus_write(REG_COMPARE, 32'h0);
        repeat (2) @(negedge clk);
        bus_read(REG_CAUSE, rd);
        check("timer clear", cause_exp(1'b0), rd);

        // Exception priority and recording, IE off
        for (int i = 0; i < N_EXC; i++) begin
            r = $urandom;
            bus_write(REG_STATUS, {9'b0, r[0], 14'b0, 6'b0, (r[2:1] == 2'b00), 1'b0});
            d = $urandom;
            issue_inst({d[31:2], 2'b00}, r[11], (r[14:12] == 3'd0) ? 7'd0 : r[22:16],
                       1'b0, $urandom, "exception");
            bus_read(REG_BADVADDR, rd);
            check("badvaddr", m_badv, rd);
        end

        // ERET target and both vectors
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            bus_write(REG_EPC, r);
            bus_write(REG_STATUS, {9'b0, i[0], 14'b0, 6'b0, 1'b1, 1'b0});
            issue_inst($urandom, 1'b0, 7'd0, 1'b1, 32'h0, "eret");
            issue_inst($urandom, 1'b0, 7'(1 << REQ_SYSC), 1'b0, 32'h0, "vector");
        end

        // Interrupt lines against IM and IE
        for (int i = 0; i < N_INT; i++) begin
            r = $urandom;
            @(negedge clk);
            hw_intr_i = r[5:0];
            m_hw = r[5:0];
            bus_write(REG_CAUSE, {22'b0, r[7:6], 8'b0});
            bus_write(REG_STATUS, {9'b0, r[8], 6'b0, r[23:16], 6'b0, 1'b0, r[9]});
            issue_inst($urandom, r[10], 7'd0, 1'b0, 32'h0, "intr");
        end
        @(negedge clk);
        hw_intr_i = '0;
        m_hw = '0;

        // Bus write to EPC colliding with an exception decision
        bus_write(REG_STATUS, 32'h0000_0002);
        bus_write(REG_EPC, 32'h1234_5678);
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i = 1'b1;
        wb_adr_i = REG_EPC;
        wb_dat_i = 32'hDEAD_BEE0;
        wb_sel_i = 4'hF;
        inst_valid_i = 1'b1;
        inst_pc_i = 32'h0040_0100;
        exc_req_i = 7'(1 << REQ_SYSC);
        @(negedge clk);
        inst_valid_i = 1'b0;
        exc_req_i = '0;
        while (!wb_ack_o) @(negedge clk);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        apply_exc(SYSC, 32'h0040_0100, 1'b0, 32'h0);
        bus_read(REG_EPC, rd);
        check("collision", 32'h1234_5678, rd);

        repeat (4) @(negedge clk);
        $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
design/cp0_pkg.sv
design/cp0_timer.sv
design/exc_prioritizer.sv
design/cp0_regs.sv
design/cp0_wb_slave.sv
design/cp0_top.sv
verif/cp0_asserts.sv
verif/cp0_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := cp0_tb
FLIST     := list.f
OBJDIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJDIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
